//--- project.f
wrr_pkg.sv
wrr_pri_rr_arb.sv
wrr_weight_accum.sv
wrr_arb.sv
wrr_arb_top.sv
wrr_tb_clk.sv
wrr_arb_asserts.sv
wrr_arb_tb.sv

//--- Makefile
# Verilator build and run for the weighted round-robin arbiter testbench

VERILATOR ?= verilator
TOP       ?= wrr_arb_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= === PASS ===

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Output goes to the terminal, the status comes from the pass search
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

//--- wrr_arb_tb.sv
// Self-checking testbench for wrr_arb_top, inputs change on the falling edge
// Grant is sampled 1 ns before each rising edge and checked against a model

`timescale 1ns/10ps

module wrr_arb_tb;

  typedef wrr_pkg::acc_t [wrr_pkg::num_req-1:0] acc_vec_t;

  // ------------------------------
  // Test lengths and limits
  // ------------------------------

  localparam int rst_cycles = 5;
  localparam int t1_cycles = 5 + 3 * wrr_pkg::num_req;
  localparam int t2_cycles = 16;
  localparam int t3_cycles = wrr_pkg::num_req + 40;
  localparam int t4_cycles = 10 + 8 + 20;
  localparam int t5_cycles = 3 + 20 + 30;
  localparam int t6_cycles = 400;
  localparam int timeout_cycles = 4 * rst_cycles + t1_cycles + t2_cycles + t3_cycles
                                + t4_cycles + t5_cycles + t6_cycles + 100;
  // Offset of the grant sample after the falling edge
  localparam int sample_delay = 4;

  logic                clk;
  logic                rst_n;
  logic                enable_priority_update;
  wrr_pkg::cfg_write_t cfg;
  wrr_pkg::req_vec_t   request;
  wrr_pkg::req_vec_t   grant;

  string       test_name = "reset";
  int          grant_errors = 0;
  int          count_errors = 0;
  int          cycle_count = 0;
  int          grant_cnt [wrr_pkg::num_req] = '{default: 0};
  logic [31:0] rng_state = 32'd32912;

  // Model state, holds the value the DUT will have after the next edge
  wrr_pkg::weight_vec_t m_weights;
  acc_vec_t             m_acc;
  wrr_pkg::req_idx_t    m_ptr;

  wrr_tb_clk u_clk (.clk(clk));

  wrr_arb_top DUT (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .enable_priority_update (enable_priority_update),
    .cfg                    (cfg),
    .request                (request),
    .grant                  (grant)
  );

  // ------------------------------
  // Reference model
  // ------------------------------

  // Credit holders win over the rest, then the first candidate after the pointer
  function automatic wrr_pkg::req_vec_t predict_grant(input wrr_pkg::req_vec_t req,
                                                      input acc_vec_t acc,
                                                      input wrr_pkg::req_idx_t ptr);
    wrr_pkg::req_vec_t hi;
    wrr_pkg::req_vec_t cand;
    wrr_pkg::req_vec_t result;
    wrr_pkg::req_idx_t idx;
    hi = '0;
    for (int i = 0; i < wrr_pkg::num_req; i++) begin
      if (req[i] && (acc[i] != '0)) begin
        hi[i] = 1'b1;
      end
    end
    cand = (hi != '0) ? hi : req;
    result = '0;
    for (int k = 1; k <= wrr_pkg::num_req; k++) begin
      idx = wrr_pkg::req_idx_t'((int'(ptr) + k) % wrr_pkg::num_req);
      if (cand[idx] && (result == '0)) begin
        result[idx] = 1'b1;
      end
    end
    return result;
  endfunction

  task automatic reset_model();
    m_acc = '0;
    m_ptr = wrr_pkg::req_idx_t'(wrr_pkg::num_req - 1);
    for (int i = 0; i < wrr_pkg::num_req; i++) begin
      m_weights[i] = wrr_pkg::weight_t'(1);
    end
  endtask

  // One rising edge: restart add, then grant spend, then pointer and table
  task automatic advance_model(input wrr_pkg::req_vec_t req, input wrr_pkg::req_vec_t g);
    logic credited;
    logic restart;
    int   sum;
    credited = 1'b0;
    for (int i = 0; i < wrr_pkg::num_req; i++) begin
      if (req[i] && (m_acc[i] != '0)) begin
        credited = 1'b1;
      end
    end
    restart = enable_priority_update && (req != '0) && !credited;
    for (int i = 0; i < wrr_pkg::num_req; i++) begin
      sum = int'(m_acc[i]);
      if (restart) begin
        sum = sum + int'(m_weights[i]);
      end
      if (sum > wrr_pkg::max_acc_weight) begin
        sum = wrr_pkg::max_acc_weight;
      end
      if (enable_priority_update && g[i] && (sum > 0)) begin
        sum = sum - 1;
      end
      m_acc[i] = wrr_pkg::acc_t'(sum);
      if (enable_priority_update && g[i]) begin
        m_ptr = wrr_pkg::req_idx_t'(i);
      end
    end
    // A new weight is only used from the following edge on
    if (cfg.valid) begin
      m_weights[cfg.index] = cfg.weight;
    end
  endtask

  // ------------------------------
  // Compare tasks
  // ------------------------------

  task automatic compare_grant(input string name, input wrr_pkg::req_vec_t expected,
                               input wrr_pkg::req_vec_t actual);
    if (actual !== expected) begin
      grant_errors++;
      $display("ERR %s: expected grant %b, actual grant %b at %0t",
               name, expected, actual, $time);
    end
  endtask

  task automatic compare_count(input string name, input wrr_pkg::acc_t expected,
                               input wrr_pkg::acc_t actual);
    if (actual !== expected) begin
      count_errors++;
      $display("ERR %s: expected count %0d, actual count %0d at %0t",
               name, expected, actual, $time);
    end
  endtask

  // Samples grant just before each rising edge and steps the model
  always begin : compare_proc
    wrr_pkg::req_vec_t expected;
    @(negedge clk);
    #(sample_delay);
    if (!rst_n) begin
      reset_model();
    end else begin
      expected = predict_grant(request, m_acc, m_ptr);
      compare_grant(test_name, expected, grant);
      for (int i = 0; i < wrr_pkg::num_req; i++) begin
        if (enable_priority_update && grant[i]) begin
          grant_cnt[i] = grant_cnt[i] + 1;
        end
      end
      advance_model(request, expected);
    end
  end

  // Hard stop if the stimulus never reaches its end
  always @(posedge clk) begin : watchdog
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Run timed out after %0d cycles without finishing the tests", timeout_cycles);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // ------------------------------
  // Stimulus helpers
  // ------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic tick(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    request = '0;
    enable_priority_update = 1'b0;
    cfg = '0;
    tick(rst_cycles);
    rst_n = 1'b1;
  endtask

  task automatic write_weight(input wrr_pkg::req_idx_t index, input wrr_pkg::weight_t weight);
    cfg.valid = 1'b1;
    cfg.index = index;
    cfg.weight = weight;
    tick(1);
    cfg = '0;
  endtask

  function automatic int count_other_grants();
    int sum;
    sum = 0;
    for (int i = 1; i < wrr_pkg::num_req; i++) begin
      sum = sum + grant_cnt[i];
    end
    return sum;
  endfunction

  initial begin : stimulus
    wrr_pkg::weight_t round_weights [wrr_pkg::num_req];
    int               start_cnt [wrr_pkg::num_req];
    int               run;
    int               start0;
    int               others_start;
    logic [31:0]      r;
    apply_reset();

    // Idle cycles, then each requester alone
    test_name = "lone_request";
    enable_priority_update = 1'b1;
    tick(5);
    for (int i = 0; i < wrr_pkg::num_req; i++) begin
      request = '0;
      request[i] = 1'b1;
      tick(3);
    end

    // All weights at 1 reduce to plain round-robin
    apply_reset();
    test_name = "default_rotation";
    enable_priority_update = 1'b1;
    request = '1;
    tick(t2_cycles);

    // With zero credit after reset, every 10 cycles form one full round
    apply_reset();
    test_name = "weighted_rounds";
    enable_priority_update = 1'b1;
    round_weights = '{3'd1, 3'd2, 3'd3, 3'd4};
    for (int i = 0; i < wrr_pkg::num_req; i++) begin
      write_weight(wrr_pkg::req_idx_t'(i), round_weights[i]);
    end
    request = '1;
    for (int w = 0; w < 4; w++) begin
      start_cnt = grant_cnt;
      tick(10);
      for (int i = 0; i < wrr_pkg::num_req; i++) begin
        compare_count(test_name, wrr_pkg::acc_t'(round_weights[i]),
                      wrr_pkg::acc_t'(grant_cnt[i] - start_cnt[i]));
      end
    end

    // Frozen cycles keep grant and state, the model catches any drift later
    test_name = "frozen_state";
    request = 4'b1011;
    tick(10);
    enable_priority_update = 1'b0;
    tick(8);
    enable_priority_update = 1'b1;
    tick(20);

    // Requesters 2 and 3 get no credit so only requester 0 builds up
    apply_reset();
    test_name = "saturation";
    enable_priority_update = 1'b1;
    write_weight(2'd0, 3'd7);
    write_weight(2'd2, 3'd0);
    write_weight(2'd3, 3'd0);
    request = 4'b0010;
    tick(20);
    request = '1;
    start0 = grant_cnt[0];
    others_start = count_other_grants();
    run = -1;
    repeat (30) begin
      tick(1);
      if ((run < 0) && (count_other_grants() != others_start)) begin
        run = grant_cnt[0] - start0;
      end
    end
    if (run < 0) begin
      count_errors++;
      $display("Saturation test: requester 0 kept the grant and was never overtaken");
    end else begin
      compare_count(test_name, wrr_pkg::acc_t'(wrr_pkg::max_acc_weight),
                    wrr_pkg::acc_t'(run));
    end

    // Random requests, enable mostly high, occasional weight writes
    test_name = "random";
    repeat (t6_cycles) begin
      rng_state = xorshift32(rng_state);
      r = rng_state;
      request = r[3:0];
      enable_priority_update = (r[7:4] != 4'd0);
      cfg = '0;
      if (r[10:8] == 3'd0) begin
        cfg.valid = 1'b1;
        cfg.index = r[12:11];
        cfg.weight = r[15:13];
      end
      tick(1);
    end
    cfg = '0;
    request = '0;
    enable_priority_update = 1'b0;
    tick(2);

    $display("grant errors: %0d, count errors: %0d, assertion failures: %0d",
             grant_errors, count_errors, DUT.u_asserts.fail_count);
    if ((grant_errors + count_errors + DUT.u_asserts.fail_count) == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- wrr_arb_asserts.sv
// Concurrent checks on the request and grant ports of wrr_arb_top
// All checks except the after-reset one are off while rst_n is low

`timescale 1ns/10ps

module wrr_arb_asserts (
  input logic              clk,
  input logic              rst_n,
  input wrr_pkg::req_vec_t request,
  input wrr_pkg::req_vec_t grant
);

  // Number of failed assertions so far
  int fail_count = 0;

  // At most one requester holds the grant in any cycle
  grant_onehot0 : assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant))
    else begin
      fail_count++;
      $error("grant is not one-hot or zero: %b", grant);
    end

  // An idle request vector never produces a grant
  grant_zero_when_idle : assert property (@(posedge clk) disable iff (!rst_n)
    (request == '0) |-> (grant == '0))
    else begin
      fail_count++;
      $error("grant %b issued with no request", grant);
    end

  // Only asserted requests can be granted
  grant_within_request : assert property (@(posedge clk) disable iff (!rst_n)
    (grant & ~request) == '0)
    else begin
      fail_count++;
      $error("grant %b outside request %b", grant, request);
    end

  // First cycle out of reset with nothing requested must be quiet
  grant_quiet_after_reset : assert property (@(posedge clk)
    (!$past(rst_n) && rst_n && (request == '0)) |-> (grant == '0))
    else begin
      fail_count++;
      $error("grant %b right after reset with no request", grant);
    end

endmodule

bind wrr_arb_top wrr_arb_asserts u_asserts (
  .clk     (clk),
  .rst_n   (rst_n),
  .request (request),
  .grant   (grant)
);

//--- wrr_tb_clk.sv
// Free-running testbench clock, 10 ns period, starts low
// First rising edge comes half a period after time zero

`timescale 1ns/10ps

module wrr_tb_clk (
  output logic clk
);

  localparam int period = 10;

  initial clk = 1'b0;

  // Toggle every half period
  always #(period / 2) clk = ~clk;

endmodule

//--- wrr_arb_top.sv
// Top level with the software weight table, entries come up at weight 1
// A write is a single-cycle strobe and takes effect on the next cycle

`timescale 1ns/10ps

module wrr_arb_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                enable_priority_update,
  input  wrr_pkg::cfg_write_t cfg,
  input  wrr_pkg::req_vec_t   request,
  output wrr_pkg::req_vec_t   grant
);

  // ------------------------------
  // Weight table
  // ------------------------------

  // One programmable weight per requester
  wrr_pkg::weight_vec_t weights;

  // Reset gives plain round-robin until software programs something else
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < wrr_pkg::num_req; i++) begin
        weights[i] <= wrr_pkg::weight_t'(1);
      end
    end else if (cfg.valid) begin
      // Only the addressed entry changes, the others keep their value
      weights[cfg.index] <= cfg.weight;
    end
  end

  // ------------------------------
  // Weighted arbiter
  // ------------------------------

  // Credit already added from an old weight stays until it is spent
  wrr_arb u_arb (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .enable_priority_update (enable_priority_update),
    .request                (request),
    .weights                (weights),
    .grant                  (grant)
  );

endmodule

//--- wrr_arb.sv
// Weighted round-robin arbiter built from credit counters and a priority arbiter
// All state is frozen while enable_priority_update is low

`timescale 1ns/10ps

module wrr_arb (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 enable_priority_update,
  input  wrr_pkg::req_vec_t    request,
  input  wrr_pkg::weight_vec_t weights,
  output wrr_pkg::req_vec_t    grant
);

  // Requesters that still hold credit
  wrr_pkg::req_vec_t request_priority;

  // ------------------------------
  // Arbitration
  // ------------------------------

  // Credit holders win first, the pointer breaks ties within a level
  wrr_pri_rr_arb u_pri_rr_arb (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .enable_priority_update (enable_priority_update),
    .request                (request),
    .request_priority       (request_priority),
    .grant                  (grant)
  );

  // ------------------------------
  // Round restart and credit spend
  // ------------------------------

  // True when at least one active requester still has credit
  logic credited_request;
  // Start of a new round, every counter is topped up by its weight
  logic incr_accumulated;
  // Grant as seen by the counters, masked so frozen cycles spend nothing
  wrr_pkg::req_vec_t decr_grant;

  assign credited_request = |(request & request_priority);

  // A round ends once every active requester has used up its credit
  assign incr_accumulated = enable_priority_update && (|request) && !credited_request;

  assign decr_grant = enable_priority_update ? grant : '0;

  // Counters feed back the priority bits that steer the next grant
  wrr_weight_accum u_weight_accum (
    .clk              (clk),
    .rst_n            (rst_n),
    .weights          (weights),
    .incr_valid       (incr_accumulated),
    .grant            (decr_grant),
    .request_priority (request_priority)
  );

endmodule

//--- wrr_weight_accum.sv
// Saturating per-requester credit counters and the derived priority bits
// Add happens before the grant decrement within the same edge

`timescale 1ns/10ps

module wrr_weight_accum (
  input  logic                 clk,
  input  logic                 rst_n,
  input  wrr_pkg::weight_vec_t weights,
  input  logic                 incr_valid,
  input  wrr_pkg::req_vec_t    grant,
  output wrr_pkg::req_vec_t    request_priority
);

  // Current credit per requester
  wrr_pkg::acc_t [wrr_pkg::num_req-1:0] acc_q;
  // Credit after the optional add, before the decrement
  wrr_pkg::acc_t [wrr_pkg::num_req-1:0] acc_add;
  wrr_pkg::acc_t [wrr_pkg::num_req-1:0] acc_d;
  // One extra bit so the raw sum cannot overflow before saturation
  logic [wrr_pkg::num_req-1:0][wrr_pkg::acc_w:0] acc_sum;

  // ------------------------------
  // Next credit value
  // ------------------------------

  always_comb begin
    for (int i = 0; i < wrr_pkg::num_req; i++) begin
      acc_sum[i] = {1'b0, acc_q[i]};
      if (incr_valid) begin
        acc_sum[i] = acc_sum[i]
                   + {{(wrr_pkg::acc_w + 1 - wrr_pkg::weight_w){1'b0}}, weights[i]};
      end
      // Clamp at the saturation value rather than wrapping
      if (acc_sum[i] > (wrr_pkg::acc_w + 1)'(wrr_pkg::max_acc_weight)) begin
        acc_add[i] = wrr_pkg::acc_t'(wrr_pkg::max_acc_weight);
      end else begin
        acc_add[i] = acc_sum[i][wrr_pkg::acc_w-1:0];
      end
      // A granted requester spends one credit, never going below zero
      acc_d[i] = acc_add[i];
      if (grant[i] && (acc_add[i] != '0)) begin
        acc_d[i] = acc_add[i] - 1'b1;
      end
      // Any remaining credit lifts the requester to high priority
      request_priority[i] = |acc_q[i];
    end
  end

  // ------------------------------
  // Credit registers
  // ------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc_q <= '0;
    end else begin
      acc_q <= acc_d;
    end
  end

endmodule

//--- wrr_pri_rr_arb.sv
// Two-level priority arbiter, grant is combinational from request and state
// Pointer moves only on enabled edges that grant something

`timescale 1ns/10ps

module wrr_pri_rr_arb (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              enable_priority_update,
  input  wrr_pkg::req_vec_t request,
  input  wrr_pkg::req_vec_t request_priority,
  output wrr_pkg::req_vec_t grant
);

  // ------------------------------
  // Candidate selection
  // ------------------------------

  // High-priority requests that are actually asserted
  wrr_pkg::req_vec_t hi_request;
  // Requests that take part in the round-robin search this cycle
  wrr_pkg::req_vec_t candidates;
  logic              any_hi;

  assign hi_request = request & request_priority;
  assign any_hi     = |hi_request;

  // Low-priority requests only compete when no high-priority one is up
  assign candidates = any_hi ? hi_request : request;

  // ------------------------------
  // Round-robin search
  // ------------------------------

  // Index of the most recent grant, the search starts just after it
  wrr_pkg::req_idx_t ptr_q;
  // Index of the requester granted this cycle
  wrr_pkg::req_idx_t grant_idx;

  // Walk the offsets from farthest to nearest so the nearest candidate
  // after the pointer is the one left standing
  always_comb begin : find_grant
    wrr_pkg::req_idx_t idx;
    grant     = '0;
    grant_idx = ptr_q;
    for (int k = wrr_pkg::num_req; k >= 1; k--) begin
      // Truncation to the index width wraps around the requester ring
      idx = wrr_pkg::req_idx_t'(ptr_q + k);
      if (candidates[idx]) begin
        grant      = '0;
        grant[idx] = 1'b1;
        grant_idx  = idx;
      end
    end
  end

  // ------------------------------
  // Pointer register
  // ------------------------------

  // Reset to the last index so requester 0 wins the first tie
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr_q <= wrr_pkg::req_idx_t'(wrr_pkg::num_req - 1);
    end else if (enable_priority_update && |grant) begin
      ptr_q <= grant_idx;
    end
  end

endmodule

//--- wrr_pkg.sv
// Sizes and types shared by the weighted round-robin arbiter
// The requester count must stay a power of two for the index arithmetic

package wrr_pkg;

  // ------------------------------
  // Sizes
  // ------------------------------

  // Number of requesters sharing the arbiter
  localparam int num_req = 4;

  // Largest weight software can program into one table entry
  localparam int max_weight = 7;

  // Accumulated credit saturates here instead of wrapping
  localparam int max_acc_weight = 15;

  // Widths derived from the values above
  localparam int weight_w = $clog2(max_weight + 1);
  localparam int acc_w = $clog2(max_acc_weight + 1);
  localparam int req_idx_w = $clog2(num_req);

  // ------------------------------
  // Types
  // ------------------------------

  // One bit per requester, used for request, grant and priority
  typedef logic [num_req-1:0] req_vec_t;

  typedef logic [weight_w-1:0] weight_t;

  // Whole weight table, entry i belongs to requester i
  typedef weight_t [num_req-1:0] weight_vec_t;

  typedef logic [acc_w-1:0] acc_t;

  typedef logic [req_idx_w-1:0] req_idx_t;

  // One-cycle weight write strobe, no acknowledge
  typedef struct packed {
    logic     valid;
    req_idx_t index;
    weight_t  weight;
  } cfg_write_t;

endpackage
